// ==== hdl/mem_defines.svh ====
`ifndef MEM_DEFINES_SVH
`define MEM_DEFINES_SVH

// data and address width
`define MEM_DATA_W 32

// request queue entries and credits granted after reset
`define MEM_FIFO_DEPTH 4

// data memory size in words
`define MEM_RAM_WORDS 256

// wait cycles per access
`define MEM_LATENCY 3

`endif

// ==== hdl/mem_pkg.sv ====
`include "mem_defines.svh"

package mem_pkg;

    typedef enum logic [3:0] {
        LB,
        LBU,
        LH,
        LHU,
        LW,
        LWL,
        LWR,
        SB,
        SH,
        SW,
        SWL,
        SWR
    } mem_op_t;

    // one memory word, seen as a whole, as bytes or as halves
    typedef union packed {
        logic [`MEM_DATA_W-1:0]          word;
        logic [`MEM_DATA_W/8-1:0][7:0]   bytes;
        logic [`MEM_DATA_W/16-1:0][15:0] halves;
    } mem_word_t;

    function automatic logic is_store_op(input mem_op_t op);
        return op inside {SB, SH, SW, SWL, SWR};
    endfunction

endpackage

// ==== hdl/mem_req_fifo.sv ====
`include "mem_defines.svh"

module mem_req_fifo import mem_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid,
    input  mem_op_t                req_op,
    input  logic [`MEM_DATA_W-1:0] req_addr,
    input  logic [`MEM_DATA_W-1:0] req_data,
    input  logic                   fifo_pop,
    output logic                   fifo_empty,
    output mem_op_t                head_op,
    output logic [`MEM_DATA_W-1:0] head_addr,
    output logic [`MEM_DATA_W-1:0] head_data,
    output logic                   credit_return
);

    localparam int PTR_W = $clog2(`MEM_FIFO_DEPTH);

    mem_op_t                op_q   [`MEM_FIFO_DEPTH];
    logic [`MEM_DATA_W-1:0] addr_q [`MEM_FIFO_DEPTH];
    logic [`MEM_DATA_W-1:0] data_q [`MEM_FIFO_DEPTH];

    // extra bit tells full from empty
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;

    assign fifo_empty = wr_ptr == rd_ptr;
    assign head_op    = op_q[rd_ptr[PTR_W-1:0]];
    assign head_addr  = addr_q[rd_ptr[PTR_W-1:0]];
    assign head_data  = data_q[rd_ptr[PTR_W-1:0]];

    always_ff @(posedge clk) begin
        if (req_valid) begin
            op_q[wr_ptr[PTR_W-1:0]]   <= req_op;
            addr_q[wr_ptr[PTR_W-1:0]] <= req_addr;
            data_q[wr_ptr[PTR_W-1:0]] <= req_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            credit_return <= 1'b0;
        end else begin
            if (req_valid)
                wr_ptr <= wr_ptr + 1'b1;
            if (fifo_pop)
                rd_ptr <= rd_ptr + 1'b1;
            // one credit back per freed entry
            credit_return <= fifo_pop;
        end
    end

endmodule

// ==== hdl/mem_wait_timer.sv ====
`include "mem_defines.svh"

module mem_wait_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic timer_start,
    output logic timer_done
);

    localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

    logic [CNT_W-1:0] count;

    // last count cycle
    assign timer_done = count == CNT_W'(1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else if (timer_start) begin
            count <= CNT_W'(`MEM_LATENCY);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

endmodule

// ==== hdl/mem_access_ctrl.sv ====
`include "mem_defines.svh"

module mem_access_ctrl import mem_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   fifo_empty,
    input  mem_op_t                head_op,
    input  logic [`MEM_DATA_W-1:0] head_addr,
    input  logic [`MEM_DATA_W-1:0] head_data,
    input  logic                   timer_done,
    input  logic                   addr_error,
    input  logic [`MEM_DATA_W-1:0] load_data,
    output logic                   fifo_pop,
    output logic                   timer_start,
    output logic                   ram_we,
    output mem_op_t                cur_op,
    output logic [`MEM_DATA_W-1:0] cur_addr,
    output logic [`MEM_DATA_W-1:0] cur_data,
    output logic                   resp_valid,
    output logic [`MEM_DATA_W-1:0] resp_data,
    output logic                   resp_error
);

    typedef enum logic [1:0] {IDLE, ACCESS, WAIT, RESPOND} state_t;

    state_t state;
    state_t state_nx;
    logic   err_q;
    logic   access_end;

    assign access_end  = (state == WAIT) && timer_done;
    assign fifo_pop    = (state == IDLE) && !fifo_empty;
    assign timer_start = (state == ACCESS) && !addr_error;
    // erroneous stores never reach WAIT
    assign ram_we      = access_end && is_store_op(cur_op);
    assign resp_valid  = state == RESPOND;
    assign resp_error  = resp_valid && err_q;

    always_comb begin
        state_nx = state;
        case (state)
            IDLE:    if (!fifo_empty) state_nx = ACCESS;
            ACCESS:  state_nx = addr_error ? RESPOND : WAIT;
            WAIT:    if (timer_done) state_nx = RESPOND;
            RESPOND: state_nx = IDLE;
            default: state_nx = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
            err_q <= 1'b0;
        end else begin
            state <= state_nx;
            if (state == ACCESS)
                err_q <= addr_error;
        end
    end

    always_ff @(posedge clk) begin
        if (fifo_pop) begin
            cur_op   <= head_op;
            cur_addr <= head_addr;
            cur_data <= head_data;
        end
        if (access_end && !is_store_op(cur_op))
            resp_data <= load_data;
    end

endmodule

// ==== hdl/load_store_align.sv ====
`include "mem_defines.svh"

module load_store_align import mem_pkg::*; (
    input  mem_op_t                  cur_op,
    input  logic [`MEM_DATA_W-1:0]   cur_addr,
    input  logic [`MEM_DATA_W-1:0]   cur_data,
    input  mem_word_t                ram_rdata,
    output logic [`MEM_DATA_W/8-1:0] ram_mask,
    output mem_word_t                ram_wdata,
    output logic [`MEM_DATA_W-1:0]   load_data,
    output logic                     addr_error
);

    localparam logic [`MEM_DATA_W-1:0] ONES = {`MEM_DATA_W{1'b1}};

    logic [1:0]  off;
    logic [4:0]  lane_sh;
    logic [4:0]  rest_sh;
    logic [7:0]  sel_byte;
    logic [15:0] sel_half;

    assign off      = cur_addr[1:0];
    // bit offset of the addressed lane, and of what lies above it
    assign lane_sh  = {off, 3'b000};
    assign rest_sh  = {~off, 3'b000};
    assign sel_byte = ram_rdata.bytes[off];
    assign sel_half = ram_rdata.halves[off[1]];

    assign addr_error = ((cur_op inside {LH, LHU, SH}) && off[0]) ||
                        ((cur_op inside {LW, SW}) && (off != 2'b00));

    always_comb begin
        load_data = '0;
        case (cur_op)
            LB:      load_data = {{(`MEM_DATA_W-8){sel_byte[7]}}, sel_byte};
            LBU:     load_data = {{(`MEM_DATA_W-8){1'b0}}, sel_byte};
            LH:      load_data = {{(`MEM_DATA_W-16){sel_half[15]}}, sel_half};
            LHU:     load_data = {{(`MEM_DATA_W-16){1'b0}}, sel_half};
            LW:      load_data = ram_rdata.word;
            // memory fills the upper bytes from the addressed lane down
            LWL:     load_data = (cur_data & ((ONES >> 8) >> lane_sh)) |
                                 (ram_rdata.word << rest_sh);
            // memory fills the lower bytes from the addressed lane up
            LWR:     load_data = (cur_data & ~(ONES >> lane_sh)) |
                                 (ram_rdata.word >> lane_sh);
            default: load_data = '0;
        endcase
    end

    always_comb begin
        ram_mask       = '0;
        ram_wdata.word = cur_data;
        case (cur_op)
            SB: begin
                ram_mask       = 4'b0001 << off;
                ram_wdata.word = {(`MEM_DATA_W/8){cur_data[7:0]}};
            end
            SH: begin
                ram_mask       = 4'b0011 << {off[1], 1'b0};
                ram_wdata.word = {(`MEM_DATA_W/16){cur_data[15:0]}};
            end
            SW: begin
                ram_mask       = 4'b1111;
                ram_wdata.word = cur_data;
            end
            SWL: begin
                ram_mask       = 4'b1111 >> ~off;
                ram_wdata.word = cur_data >> rest_sh;
            end
            SWR: begin
                ram_mask       = 4'b1111 << off;
                ram_wdata.word = cur_data << lane_sh;
            end
            default: begin
                // loads touch no lane
                ram_mask       = '0;
                ram_wdata.word = cur_data;
            end
        endcase
    end

endmodule

// ==== hdl/data_ram.sv ====
`include "mem_defines.svh"

module data_ram import mem_pkg::*; (
    input  logic                     clk,
    input  logic                     ram_we,
    input  logic [`MEM_DATA_W-1:0]   ram_addr,
    input  logic [`MEM_DATA_W/8-1:0] ram_mask,
    input  mem_word_t                ram_wdata,
    output mem_word_t                ram_rdata
);

    localparam int IDX_W = $clog2(`MEM_RAM_WORDS);

    mem_word_t        mem [`MEM_RAM_WORDS];
    logic [IDX_W-1:0] word_idx;

    // byte address to word index modulo the memory size
    assign word_idx  = ram_addr[IDX_W+1:2];
    assign ram_rdata = mem[word_idx];

    always_ff @(posedge clk) begin
        if (ram_we) begin
            for (int i = 0; i < `MEM_DATA_W/8; i++) begin
                if (ram_mask[i])
                    mem[word_idx].bytes[i] <= ram_wdata.bytes[i];
            end
        end
    end

endmodule

// ==== hdl/mem_access_unit.sv ====
`include "mem_defines.svh"

module mem_access_unit import mem_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid,
    input  mem_op_t                req_op,
    input  logic [`MEM_DATA_W-1:0] req_addr,
    input  logic [`MEM_DATA_W-1:0] req_data,
    output logic                   credit_return,
    output logic                   resp_valid,
    output logic [`MEM_DATA_W-1:0] resp_data,
    output logic                   resp_error
);

    logic                     fifo_empty;
    logic                     fifo_pop;
    mem_op_t                  head_op;
    logic [`MEM_DATA_W-1:0]   head_addr;
    logic [`MEM_DATA_W-1:0]   head_data;
    logic                     timer_start;
    logic                     timer_done;
    logic                     ram_we;
    mem_op_t                  cur_op;
    logic [`MEM_DATA_W-1:0]   cur_addr;
    logic [`MEM_DATA_W-1:0]   cur_data;
    logic [`MEM_DATA_W/8-1:0] ram_mask;
    mem_word_t                ram_wdata;
    mem_word_t                ram_rdata;
    logic [`MEM_DATA_W-1:0]   load_data;
    logic                     addr_error;

    mem_req_fifo i_fifo (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req_op        (req_op),
        .req_addr      (req_addr),
        .req_data      (req_data),
        .fifo_pop      (fifo_pop),
        .fifo_empty    (fifo_empty),
        .head_op       (head_op),
        .head_addr     (head_addr),
        .head_data     (head_data),
        .credit_return (credit_return)
    );

    mem_access_ctrl i_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .fifo_empty  (fifo_empty),
        .head_op     (head_op),
        .head_addr   (head_addr),
        .head_data   (head_data),
        .timer_done  (timer_done),
        .addr_error  (addr_error),
        .load_data   (load_data),
        .fifo_pop    (fifo_pop),
        .timer_start (timer_start),
        .ram_we      (ram_we),
        .cur_op      (cur_op),
        .cur_addr    (cur_addr),
        .cur_data    (cur_data),
        .resp_valid  (resp_valid),
        .resp_data   (resp_data),
        .resp_error  (resp_error)
    );

    mem_wait_timer i_timer (
        .clk         (clk),
        .rst_n       (rst_n),
        .timer_start (timer_start),
        .timer_done  (timer_done)
    );

    load_store_align i_align (
        .cur_op     (cur_op),
        .cur_addr   (cur_addr),
        .cur_data   (cur_data),
        .ram_rdata  (ram_rdata),
        .ram_mask   (ram_mask),
        .ram_wdata  (ram_wdata),
        .load_data  (load_data),
        .addr_error (addr_error)
    );

    data_ram i_ram (
        .clk       (clk),
        .ram_we    (ram_we),
        .ram_addr  (cur_addr),
        .ram_mask  (ram_mask),
        .ram_wdata (ram_wdata),
        .ram_rdata (ram_rdata)
    );

endmodule

// ==== test/mem_access_unit_asserts.sv ====
`include "mem_defines.svh"

module mem_access_unit_asserts (
    input logic clk,
    input logic rst_n,
    input logic req_valid,
    input logic credit_return,
    input logic resp_valid,
    input logic resp_error,
    input logic ram_we
);

    timeunit 1ns;
    timeprecision 1ps;

    // credits spent by the requester and not yet returned
    int outstanding;
    int outstanding_nx;

    assign outstanding_nx = outstanding + int'(req_valid) - int'(credit_return);

    always_ff @(posedge clk) begin
        if (!rst_n)
            outstanding <= 0;
        else
            outstanding <= outstanding_nx;
    end

    credit_limit: assert property (@(posedge clk) disable iff (!rst_n)
        outstanding_nx >= 0 && outstanding_nx <= `MEM_FIFO_DEPTH)
        else $error("outstanding request count outside zero to queue depth");

    resp_single_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |=> !resp_valid)
        else $error("resp_valid stayed high for more than one cycle");

    // a write belongs to a store whose response follows without error
    no_write_on_error: assert property (@(posedge clk) disable iff (!rst_n)
        ram_we |=> resp_valid && !resp_error)
        else $error("RAM write not followed by an error-free response");

    credit_idle_after_reset: assert property (@(posedge clk)
        !rst_n |=> !credit_return)
        else $error("credit_return high right after reset");

endmodule

bind mem_access_unit mem_access_unit_asserts i_asserts (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid     (req_valid),
    .credit_return (credit_return),
    .resp_valid    (resp_valid),
    .resp_error    (resp_error),
    .ram_we        (ram_we)
);

// ==== test/mem_access_unit_tb.sv ====
`include "mem_defines.svh"

module mem_access_unit_tb import mem_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 200;

    logic                   clk;
    logic                   rst_n;
    logic                   req_valid;
    mem_op_t                req_op;
    logic [`MEM_DATA_W-1:0] req_addr;
    logic [`MEM_DATA_W-1:0] req_data;
    logic                   credit_return;
    logic                   resp_valid;
    logic [`MEM_DATA_W-1:0] resp_data;
    logic                   resp_error;

    // test table with expected values from the shadow memory
    string       name_q[$];
    mem_op_t     op_q[$];
    logic [31:0] addr_q[$];
    logic [31:0] data_q[$];
    logic [31:0] exp_q[$];
    bit          err_q[$];

    logic [7:0] shadow [1024];
    int         seed = 32'haed5;
    int         passed;
    int         failed;
    bit         timed_out;

    mem_access_unit i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .req_valid     (req_valid),
        .req_op        (req_op),
        .req_addr      (req_addr),
        .req_data      (req_data),
        .credit_return (credit_return),
        .resp_valid    (resp_valid),
        .resp_data     (resp_data),
        .resp_error    (resp_error)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // appends one test and applies it to the shadow memory
    task automatic add_test(input string name, input mem_op_t op, input int addr,
                            input logic [31:0] data, input bit err);
        int          base;
        int          k;
        logic [7:0]  m [4];
        logic [7:0]  r [4];
        logic [15:0] h;
        logic [31:0] expected;
        base = addr & 32'h3fc;
        k    = addr & 3;
        for (int j = 0; j < 4; j++) begin
            m[j] = shadow[base + j];
            r[j] = data[8*j +: 8];
        end
        expected = '0;
        if (!err) begin
            case (op)
                LB:  expected = {{24{m[k][7]}}, m[k]};
                LBU: expected = {24'h0, m[k]};
                LH, LHU: begin
                    h        = {m[k + 1], m[k]};
                    expected = (op == LH) ? {{16{h[15]}}, h} : {16'h0, h};
                end
                LW:  expected = {m[3], m[2], m[1], m[0]};
                // memory fills the top bytes and the register keeps the rest
                LWL: begin
                    for (int j = 3 - k; j < 4; j++)
                        r[j] = m[j + k - 3];
                    expected = {r[3], r[2], r[1], r[0]};
                end
                LWR: begin
                    for (int j = 0; j <= 3 - k; j++)
                        r[j] = m[j + k];
                    expected = {r[3], r[2], r[1], r[0]};
                end
                SB:  shadow[base + k] = data[7:0];
                SH: begin
                    shadow[base + k]     = data[7:0];
                    shadow[base + k + 1] = data[15:8];
                end
                SW: begin
                    for (int j = 0; j < 4; j++)
                        shadow[base + j] = r[j];
                end
                SWL: begin
                    for (int j = 0; j <= k; j++)
                        shadow[base + j] = r[j + 3 - k];
                end
                SWR: begin
                    for (int j = k; j < 4; j++)
                        shadow[base + j] = r[j - k];
                end
                default: expected = '0;
            endcase
        end
        name_q.push_back(name);
        op_q.push_back(op);
        addr_q.push_back(addr);
        data_q.push_back(data);
        exp_q.push_back(expected);
        err_q.push_back(err);
    endtask

    task automatic build_table();
        for (int i = 0; i < 1024; i++)
            shadow[i] = 8'h00;
        add_test("sw_known", SW, 0, 32'h8a5c_f17e, 0);
        for (int k = 0; k < 4; k++) begin
            add_test($sformatf("lb_%0d", k), LB, k, 0, 0);
            add_test($sformatf("lbu_%0d", k), LBU, k, 0, 0);
        end
        for (int k = 0; k < 4; k += 2) begin
            add_test($sformatf("lh_%0d", k), LH, k, 0, 0);
            add_test($sformatf("lhu_%0d", k), LHU, k, 0, 0);
        end
        add_test("lw_known", LW, 0, 0, 0);
        // byte and half stores into filled words
        add_test("sw_fill_10", SW, 'h10, 32'h1122_3344, 0);
        for (int k = 0; k < 4; k++) begin
            add_test($sformatf("sb_%0d", k), SB, 'h10 + k, 32'hffff_ffa0 + k, 0);
            add_test($sformatf("lw_after_sb_%0d", k), LW, 'h10, 0, 0);
        end
        add_test("sw_fill_14", SW, 'h14, 32'h5566_7788, 0);
        for (int k = 0; k < 4; k += 2) begin
            add_test($sformatf("sh_%0d", k), SH, 'h14 + k, 32'hbeef_c0d0 + k, 0);
            add_test($sformatf("lw_after_sh_%0d", k), LW, 'h14, 0, 0);
        end
        // misaligned accesses leave word 0 alone
        add_test("lh_odd", LH, 1, 0, 1);
        add_test("lhu_odd", LHU, 3, 0, 1);
        add_test("sh_odd", SH, 1, 32'h0000_ffff, 1);
        add_test("lw_off2", LW, 2, 0, 1);
        add_test("sw_off3", SW, 3, 32'hffff_ffff, 1);
        add_test("sw_off1", SW, 1, 32'hffff_ffff, 1);
        add_test("lw_unchanged", LW, 0, 0, 0);
        for (int k = 0; k < 4; k++) begin
            add_test($sformatf("lwl_%0d", k), LWL, k, 32'hdead_beef, 0);
            add_test($sformatf("lwr_%0d", k), LWR, k, 32'hdead_beef, 0);
        end
        for (int k = 0; k < 4; k++) begin
            add_test($sformatf("sw_fill_swl_%0d", k), SW, 'h20 + 4*k, 32'hc0c1_c2c3, 0);
            add_test($sformatf("swl_%0d", k), SWL, 'h20 + 5*k, 32'ha1b2_c3d4, 0);
            add_test($sformatf("lw_after_swl_%0d", k), LW, 'h20 + 4*k, 0, 0);
            add_test($sformatf("sw_fill_swr_%0d", k), SW, 'h30 + 4*k, 32'hc0c1_c2c3, 0);
            add_test($sformatf("swr_%0d", k), SWR, 'h30 + 5*k, 32'ha1b2_c3d4, 0);
            add_test($sformatf("lw_after_swr_%0d", k), LW, 'h30 + 4*k, 0, 0);
        end
        // random words written and read back in request order
        for (int i = 0; i < `MEM_FIFO_DEPTH; i++)
            add_test($sformatf("burst_sw_%0d", i), SW, 'h40 + 4*i, $random(seed), 0);
        for (int i = 0; i < `MEM_FIFO_DEPTH; i++)
            add_test($sformatf("burst_lw_%0d", i), LW, 'h40 + 4*i, 0, 0);
    endtask

    task automatic send_requests();
        int credits;
        int idx;
        int idle;
        credits = `MEM_FIFO_DEPTH;
        idx     = 0;
        idle    = 0;
        while (idx < name_q.size() && !timed_out) begin
            @(posedge clk);
            #2;
            if (credit_return)
                credits++;
            if (credits > 0) begin
                req_valid = 1'b1;
                req_op    = op_q[idx];
                req_addr  = addr_q[idx];
                req_data  = data_q[idx];
                credits--;
                idx++;
                idle = 0;
            end else begin
                req_valid = 1'b0;
                idle++;
                if (idle > TIMEOUT) begin
                    $display("timeout, no credit came back within %0d cycles", TIMEOUT);
                    timed_out = 1'b1;
                end
            end
        end
        @(posedge clk);
        #2;
        req_valid = 1'b0;
    endtask

    task automatic collect_responses();
        int wait_cnt;
        int returned;
        bit ok;
        returned = 0;
        for (int i = 0; i < name_q.size(); i++) begin
            wait_cnt = 0;
            do begin
                @(posedge clk);
                #2;
                wait_cnt++;
                if (credit_return)
                    returned++;
            end while (!resp_valid && wait_cnt < TIMEOUT && !timed_out);
            if (!resp_valid) begin
                if (!timed_out)
                    $display("timeout, no response for %s within %0d cycles", name_q[i], TIMEOUT);
                timed_out = 1'b1;
                break;
            end
            ok = 1'b1;
            assert (resp_error === err_q[i]) else begin
                $display("mismatch %s error flag expected %0b actual %0b",
                         name_q[i], err_q[i], resp_error);
                ok = 1'b0;
            end
            // one access at a time, so every popped request has its credit back by now
            assert (returned == i + 1) else begin
                $display("mismatch %s credits returned expected %0d actual %0d",
                         name_q[i], i + 1, returned);
                ok = 1'b0;
            end
            if (!err_q[i] && (op_q[i] inside {LB, LBU, LH, LHU, LW, LWL, LWR})) begin
                assert (resp_data === exp_q[i]) else begin
                    $display("mismatch %s data expected %h actual %h",
                             name_q[i], exp_q[i], resp_data);
                    ok = 1'b0;
                end
            end
            $display("%s %s", ok ? "pass" : "fail", name_q[i]);
            if (ok)
                passed++;
            else
                failed++;
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req_op    = LB;
        req_addr  = '0;
        req_data  = '0;
        passed    = 0;
        failed    = 0;
        timed_out = 1'b0;
        build_table();
        repeat (10) @(posedge clk);
        #2;
        rst_n = 1'b1;
        fork
            send_requests();
            collect_responses();
        join
        $display("tests %0d passed %0d failed %0d", name_q.size(), passed, failed);
        if (failed == 0 && !timed_out && passed == name_q.size()) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== mem_access_unit.f ====
+incdir+hdl
hdl/mem_pkg.sv
hdl/mem_req_fifo.sv
hdl/mem_wait_timer.sv
hdl/mem_access_ctrl.sv
hdl/load_store_align.sv
hdl/data_ram.sv
hdl/mem_access_unit.sv
test/mem_access_unit_asserts.sv
test/mem_access_unit_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then search the log for the pass line
rm -f sim.log &&
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module mem_access_unit_tb -f mem_access_unit.f -o mem_access_unit_sim &&
./obj_dir/mem_access_unit_sim > sim.log 2>&1 ||
echo "simulation did not complete"
grep -q "NO ERRORS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }
